/* Makefile */
VERILATOR ?= verilator
TOP       := tb_adc_acq
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0 --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+src
src/acq_pkg.sv
src/acq_sequencer.sv
src/adc_bus_master.sv
src/adc_setup.sv
src/adc_convert.sv
src/frame_fifo.sv
src/frame_to_ram.sv
src/sample_ram.sv
src/adc_acq_top.sv
tb/adc_model.sv
tb/tb_adc_acq.sv

/* src/acq_cfg.svh */
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// Run shape
`define ACQ_NUM_FRAMES   8
`define ACQ_WAIT_CYCLES  16     // Power-up wait
`define ACQ_FIFO_DEPTH   4

// ADC register map
`define ADC_REG_RESET    8'h00
`define ADC_REG_TYPE     8'h01
`define ADC_REG_TEMP     8'h02  // High byte, low byte at +1
`define ADC_REG_CONF     8'h04
`define ADC_REG_CONV     8'h05
`define ADC_REG_CH0      8'h10  // Channels at CH0 to CH0+7

`define ADC_CONF_VALUE   8'h3C

`endif

/* src/acq_pkg.sv */
package acq_pkg;

    // Sequencer states, also the step select of the setup stage
    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        INIT,
        TYPE,
        CONF,
        CONV,
        FINISH
    } acq_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } adc_op_e;

    // One register bus transfer
    typedef struct packed {
        adc_op_e    op;
        logic [7:0] addr;
        logic [7:0] wdata;
    } adc_cmd_t;

    typedef struct packed {
        logic [7:0] ch7;
        logic [7:0] ch6;
        logic [7:0] ch5;
        logic [7:0] ch4;
        logic [7:0] ch3;
        logic [7:0] ch2;
        logic [7:0] ch1;
        logic [7:0] ch0;
    } sample_frame_t;

    typedef struct packed {
        logic [7:0]  device_type;
        logic [15:0] device_temp;
    } acq_status_t;

endpackage

/* src/acq_sequencer.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_sequencer import acq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic       done,
    input  logic [3:0] frames_stored,
    output logic       fs_setup,
    output logic       fs_conv,
    input  logic       fd_setup,
    input  logic       fd_conv,
    output acq_state_e setup_step
);
    localparam int WAIT_W = $clog2(`ACQ_WAIT_CYCLES + 1);

    acq_state_e state;
    acq_state_e step_next;
    logic [WAIT_W-1:0] wait_cnt;
    logic [3:0] conv_cnt;
    logic fs_q;
    logic fd_seen;   // fd rose, waiting for it to fall
    logic fd;

    assign fd = (state == CONV) ? fd_conv : fd_setup;
    assign fs_setup = fs_q && (state != CONV);
    assign fs_conv = fs_q && (state == CONV);
    assign setup_step = state;

    always_comb begin
        case (state)
            INIT: step_next = TYPE;
            TYPE: step_next = CONF;
            CONF: step_next = CONV;
            default: step_next = (conv_cnt == 4'(`ACQ_NUM_FRAMES - 1)) ? FINISH : CONV;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            wait_cnt <= '0;
            conv_cnt <= '0;
            fs_q <= 1'b0;
            fd_seen <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WAIT;
                        wait_cnt <= '0;
                        conv_cnt <= '0;
                    end
                end
                WAIT: begin
                    if (wait_cnt == WAIT_W'(`ACQ_WAIT_CYCLES - 1)) begin
                        state <= INIT;
                        fs_q <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                INIT, TYPE, CONF, CONV: begin
                    if (fs_q && fd) begin
                        fs_q <= 1'b0;
                        fd_seen <= 1'b1;
                    end else if (fd_seen && !fd) begin
                        fd_seen <= 1'b0;
                        state <= step_next;
                        fs_q <= (step_next != FINISH);
                        if (state == CONV)
                            conv_cnt <= conv_cnt + 1'b1;
                    end
                end
                FINISH: begin
                    if (!done && frames_stored == 4'(`ACQ_NUM_FRAMES)) begin
                        done <= 1'b1;
                    end else if (done && !start) begin
                        done <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* src/adc_acq_top.sv */
`timescale 1ns/1ps

module adc_acq_top import acq_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [11:0] ram_base,
    output logic        done,
    output acq_status_t status,
    input  logic [11:0] rd_addr,
    output logic [7:0]  rd_data,
    output adc_cmd_t    adc_cmd,
    output logic        adc_req,
    input  logic        adc_ack,
    input  logic [7:0]  adc_rdata
);
    logic fs_setup;
    logic fd_setup;
    logic fs_conv;
    logic fd_conv;
    acq_state_e setup_step;
    logic [3:0] frames_stored;

    adc_cmd_t setup_cmd;
    adc_cmd_t conv_cmd;
    logic setup_cmd_valid;
    logic conv_cmd_valid;
    logic rsp_valid;
    logic [7:0] rsp_data;

    logic push;
    logic full;
    logic pop;
    logic empty;
    sample_frame_t wr_frame;
    sample_frame_t rd_frame;

    logic we;
    logic [11:0] waddr;
    logic [7:0] wdata;

    acq_sequencer sequencer_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .done(done),
        .frames_stored(frames_stored),
        .fs_setup(fs_setup),
        .fs_conv(fs_conv),
        .fd_setup(fd_setup),
        .fd_conv(fd_conv),
        .setup_step(setup_step)
    );

    adc_bus_master bus_master_inst (
        .clk(clk),
        .rst(rst),
        .cmd({conv_cmd, setup_cmd}),
        .cmd_valid({conv_cmd_valid, setup_cmd_valid}),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data),
        .adc_cmd(adc_cmd),
        .adc_req(adc_req),
        .adc_ack(adc_ack),
        .adc_rdata(adc_rdata)
    );

    adc_setup setup_inst (
        .clk(clk),
        .rst(rst),
        .fs(fs_setup),
        .step(setup_step),
        .fd(fd_setup),
        .cmd(setup_cmd),
        .cmd_valid(setup_cmd_valid),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data),
        .status(status)
    );

    adc_convert convert_inst (
        .clk(clk),
        .rst(rst),
        .fs(fs_conv),
        .fd(fd_conv),
        .cmd(conv_cmd),
        .cmd_valid(conv_cmd_valid),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data),
        .push(push),
        .frame(wr_frame),
        .full(full)
    );

    frame_fifo fifo_inst (
        .clk(clk),
        .rst(rst),
        .push(push),
        .wr_frame(wr_frame),
        .full(full),
        .pop(pop),
        .rd_frame(rd_frame),
        .empty(empty)
    );

    frame_to_ram writer_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .ram_base(ram_base),
        .rd_frame(rd_frame),
        .empty(empty),
        .pop(pop),
        .we(we),
        .waddr(waddr),
        .wdata(wdata),
        .frames_stored(frames_stored)
    );

    sample_ram ram_inst (
        .clk(clk),
        .we(we),
        .waddr(waddr),
        .wdata(wdata),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

/* src/adc_bus_master.sv */
`timescale 1ns/1ps

module adc_bus_master import acq_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  adc_cmd_t [1:0] cmd,        // Setup stage in 0, conversion in 1
    input  logic [1:0]     cmd_valid,
    output logic           rsp_valid,
    output logic [7:0]     rsp_data,
    output adc_cmd_t       adc_cmd,
    output logic           adc_req,
    input  logic           adc_ack,
    input  logic [7:0]     adc_rdata
);
    typedef enum logic [1:0] {
        BM_IDLE,
        BM_REQ,
        BM_RELEASE,
        BM_RSP
    } bm_state_e;

    bm_state_e state;
    adc_cmd_t cmd_sel;

    // Only one stage is active, so masking and OR picks its command
    assign cmd_sel = adc_cmd_t'((cmd[0] & {$bits(adc_cmd_t){cmd_valid[0]}}) |
                                (cmd[1] & {$bits(adc_cmd_t){cmd_valid[1]}}));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= BM_IDLE;
            adc_req <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                BM_IDLE: begin
                    if (|cmd_valid) begin
                        adc_req <= 1'b1;
                        state <= BM_REQ;
                    end
                end
                BM_REQ: begin
                    if (adc_ack) begin
                        adc_req <= 1'b0;
                        state <= BM_RELEASE;
                    end
                end
                BM_RELEASE: begin
                    if (!adc_ack) begin   // Slave released, transfer complete
                        rsp_valid <= 1'b1;
                        state <= BM_RSP;
                    end
                end
                default: state <= BM_IDLE;   // Stage drops cmd_valid here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BM_IDLE && |cmd_valid)
            adc_cmd <= cmd_sel;
        if (state == BM_REQ && adc_ack)
            rsp_data <= adc_rdata;
    end

endmodule

/* src/adc_convert.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_convert import acq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          fs,
    output logic          fd,
    output adc_cmd_t      cmd,
    output logic          cmd_valid,
    input  logic          rsp_valid,
    input  logic [7:0]    rsp_data,
    output logic          push,
    output sample_frame_t frame,
    input  logic          full
);
    logic [3:0] idx;    // 0 is the CONV write, 1 to 8 the channel reads
    logic pend;         // Frame complete, waiting for FIFO room

    assign push = pend && !full;

    always_comb begin
        cmd.op = (idx == 4'd0) ? OP_WRITE : OP_READ;
        cmd.addr = (idx == 4'd0) ? `ADC_REG_CONV : `ADC_REG_CH0 + {4'd0, idx} - 8'd1;
        cmd.wdata = 8'h01;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd <= 1'b0;
            cmd_valid <= 1'b0;
            idx <= '0;
            pend <= 1'b0;
        end else if (!fs) begin
            fd <= 1'b0;
            cmd_valid <= 1'b0;
            idx <= '0;
            pend <= 1'b0;
        end else if (pend) begin
            if (!full) begin
                pend <= 1'b0;
                fd <= 1'b1;
            end
        end else if (cmd_valid) begin
            if (rsp_valid) begin
                cmd_valid <= 1'b0;
                if (idx == 4'd8)   // CH7 back
                    pend <= 1'b1;
                else
                    idx <= idx + 1'b1;
            end
        end else if (!fd) begin
            cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && rsp_valid && idx != 4'd0)
            frame <= {rsp_data, frame[63:8]};   // CH0 ends in the low byte
    end

endmodule

/* src/adc_setup.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_setup import acq_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fs,
    input  acq_state_e  step,
    output logic        fd,
    output adc_cmd_t    cmd,
    output logic        cmd_valid,
    input  logic        rsp_valid,
    input  logic [7:0]  rsp_data,
    output acq_status_t status
);
    logic [1:0] idx;        // Transfer within the step
    logic [1:0] last_idx;

    assign last_idx = (step == TYPE) ? 2'd2 : 2'd0;

    always_comb begin
        cmd.op = OP_READ;
        cmd.addr = `ADC_REG_TYPE;
        cmd.wdata = 8'h00;
        case (step)
            INIT: begin
                cmd.op = OP_WRITE;
                cmd.addr = `ADC_REG_RESET;
            end
            TYPE: begin
                if (idx != 2'd0)
                    cmd.addr = `ADC_REG_TEMP + {6'd0, idx} - 8'd1;
            end
            CONF: begin
                cmd.op = OP_WRITE;
                cmd.addr = `ADC_REG_CONF;
                cmd.wdata = `ADC_CONF_VALUE;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd <= 1'b0;
            cmd_valid <= 1'b0;
            idx <= '0;
        end else if (!fs) begin
            fd <= 1'b0;
            cmd_valid <= 1'b0;
            idx <= '0;
        end else if (cmd_valid) begin
            if (rsp_valid) begin
                cmd_valid <= 1'b0;
                if (idx == last_idx)
                    fd <= 1'b1;
                else
                    idx <= idx + 1'b1;
            end
        end else if (!fd) begin
            cmd_valid <= 1'b1;
        end
    end

    // Type byte, then temperature high and low
    always_ff @(posedge clk) begin
        if (cmd_valid && rsp_valid && step == TYPE) begin
            case (idx)
                2'd0: status.device_type <= rsp_data;
                2'd1: status.device_temp[15:8] <= rsp_data;
                default: status.device_temp[7:0] <= rsp_data;
            endcase
        end
    end

endmodule

/* src/frame_fifo.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module frame_fifo import acq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  sample_frame_t wr_frame,
    output logic          full,
    input  logic          pop,
    output sample_frame_t rd_frame,
    output logic          empty
);
    localparam int AW = $clog2(`ACQ_FIFO_DEPTH);

    sample_frame_t mem [`ACQ_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;
    logic wr_en;
    logic rd_en;

    assign full = (count == (AW+1)'(`ACQ_FIFO_DEPTH));
    assign empty = (count == '0);
    assign rd_frame = mem[rd_ptr];   // Head is visible while not empty
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + wr_en - rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_frame;
    end

endmodule

/* src/frame_to_ram.sv */
`timescale 1ns/1ps

module frame_to_ram import acq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic [11:0]   ram_base,
    input  sample_frame_t rd_frame,
    input  logic          empty,
    output logic          pop,
    output logic          we,
    output logic [11:0]   waddr,
    output logic [7:0]    wdata,
    output logic [3:0]    frames_stored
);
    logic start_q;
    logic [2:0] byte_idx;
    logic [63:0] frame_bits;

    assign frame_bits = rd_frame;
    assign we = !empty;
    assign wdata = frame_bits[{byte_idx, 3'b000} +: 8];
    assign pop = we && (byte_idx == 3'd7);   // Last byte of the head frame

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b0;
            waddr <= '0;
            byte_idx <= '0;
            frames_stored <= '0;
        end else begin
            start_q <= start;
            if (start && !start_q) begin
                waddr <= ram_base;
                byte_idx <= '0;
                frames_stored <= '0;
            end else if (we) begin
                waddr <= waddr + 1'b1;   // Wraps at 4096
                byte_idx <= byte_idx + 1'b1;
                if (pop)
                    frames_stored <= frames_stored + 1'b1;
            end
        end
    end

endmodule

/* src/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram (
    input  logic        clk,
    input  logic        we,
    input  logic [11:0] waddr,
    input  logic [7:0]  wdata,
    input  logic [11:0] rd_addr,
    output logic [7:0]  rd_data
);
    logic [7:0] mem [4096];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rd_data <= mem[rd_addr];
    end

endmodule

/* tb/adc_model.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_model import acq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  adc_cmd_t   adc_cmd,
    input  logic       adc_req,
    output logic       adc_ack,
    output logic [7:0] adc_rdata,
    output logic       reset_seen,
    output logic       conf_in_order,   // CONF written after a RESET write
    output logic [7:0] conf_value
);
    logic busy;
    logic [2:0] delay;
    int unsigned conv_count;
    int unsigned conv_num;     // Conversion the channel reads belong to

    function automatic logic [7:0] read_reg(logic [7:0] addr);
        logic [7:0] ch;
        logic [31:0] raw;
        ch = addr - `ADC_REG_CH0;
        raw = conv_num * 16 + 32'(ch) * 3;
        if (addr == `ADC_REG_TYPE)
            return 8'h5A;
        else if (addr == `ADC_REG_TEMP)
            return 8'h12;
        else if (addr == `ADC_REG_TEMP + 8'd1)
            return 8'h34;
        else if (addr >= `ADC_REG_CH0 && addr < `ADC_REG_CH0 + 8'd8)
            return raw[7:0] ^ conf_value;
        return 8'h00;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_ack <= 1'b0;
            adc_rdata <= '0;
            busy <= 1'b0;
            delay <= '0;
            reset_seen <= 1'b0;
            conf_in_order <= 1'b0;
            conf_value <= '0;
            conv_count <= 0;
            conv_num <= 0;
        end else if (adc_ack) begin
            if (!adc_req) begin   // Master released, end of transfer
                adc_ack <= 1'b0;
                busy <= 1'b0;
            end
        end else if (adc_req) begin
            if (!busy) begin
                busy <= 1'b1;
                delay <= 3'($urandom % 6);
            end else if (delay != 3'd0) begin
                delay <= delay - 1'b1;
            end else begin
                adc_ack <= 1'b1;
                adc_rdata <= read_reg(adc_cmd.addr);
                if (adc_cmd.op == OP_WRITE) begin
                    case (adc_cmd.addr)
                        `ADC_REG_RESET: reset_seen <= 1'b1;
                        `ADC_REG_CONF: begin
                            conf_value <= adc_cmd.wdata;
                            conf_in_order <= reset_seen;
                        end
                        `ADC_REG_CONV: begin
                            conv_num <= conv_count;
                            conv_count <= conv_count + 1;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

/* tb/tb_adc_acq.sv */
`timescale 1ns/1ps
`include "acq_cfg.svh"

module tb_adc_acq import acq_pkg::*; ();
    // Worst case of about 12 cycles per bus transfer
    localparam int RUN_CYCLES = `ACQ_WAIT_CYCLES + 11 + `ACQ_NUM_FRAMES * 9 * 12;
    localparam int READ_CYCLES = 3 * (`ACQ_NUM_FRAMES * 8) + 64;
    localparam int TIMEOUT_CYCLES = 2 * (2 * RUN_CYCLES + READ_CYCLES) + 200;
    localparam logic [7:0] CONF_EXP = 8'h3C;
    localparam logic [11:0] BASE_A = 12'h010;
    localparam logic [11:0] BASE_B = 12'hFF8;
    localparam int KEPT_FIRST = ((int'(BASE_B) + 64) % 4096) - int'(BASE_A);

    logic clk;
    logic rst;
    logic start;
    logic [11:0] ram_base;
    logic done;
    acq_status_t status;
    logic [11:0] rd_addr;
    logic [7:0] rd_data;
    adc_cmd_t adc_cmd;
    logic adc_req;
    logic adc_ack;
    logic [7:0] adc_rdata;
    logic reset_seen;
    logic conf_in_order;
    logic [7:0] conf_value;

    int unsigned cycle_cnt;
    logic rd_check;
    logic [7:0] rd_exp;
    logic chk_q;            // Read issued one cycle back
    logic [7:0] exp_q;
    logic [11:0] addr_q;
    logic req_q;
    logic ack_q;
    adc_cmd_t cmd_q;

    adc_acq_top adc_acq_top_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .ram_base(ram_base),
        .done(done),
        .status(status),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .adc_cmd(adc_cmd),
        .adc_req(adc_req),
        .adc_ack(adc_ack),
        .adc_rdata(adc_rdata)
    );

    adc_model adc_model_inst (
        .clk(clk),
        .rst(rst),
        .adc_cmd(adc_cmd),
        .adc_req(adc_req),
        .adc_ack(adc_ack),
        .adc_rdata(adc_rdata),
        .reset_seen(reset_seen),
        .conf_in_order(conf_in_order),
        .conf_value(conf_value)
    );

    // Channel c of conversion n
    function automatic logic [7:0] expected_sample(int conv_num, int ch);
        logic [31:0] raw;
        raw = 32'(conv_num * 16 + ch * 3);
        return raw[7:0] ^ CONF_EXP;
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got %0h, expected %0h", name, got, exp));
    endtask

    task automatic run_acquisition(logic [11:0] base);
        @(posedge clk);
        ram_base <= base;
        start <= 1'b1;
        while (done !== 1'b1)
            @(negedge clk);
        repeat (5) begin   // done holds while start is high
            @(negedge clk);
            compare_value("done", 32'(done), 32'(1'b1));
        end
        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(negedge clk);
        if (done !== 1'b0)
            abort_run("done did not fall after start was released");
    endtask

    task automatic verify_bytes(logic [11:0] base, int first_conv, int first_idx, int last_idx);
        int i;
        for (i = first_idx; i <= last_idx; i++) begin
            @(posedge clk);
            rd_addr <= base + 12'(i);
            rd_exp <= expected_sample(first_conv + i / 8, i % 8);
            rd_check <= 1'b1;
        end
        @(posedge clk);
        rd_check <= 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle_cnt));
    end

    // RAM read data arrives one cycle after the address
    always @(posedge clk) begin
        chk_q <= rd_check;
        exp_q <= rd_exp;
        addr_q <= rd_addr;
    end

    always @(negedge clk) begin
        if (chk_q)
            compare_value($sformatf("rd_data[%03h]", addr_q), 32'(rd_data), 32'(exp_q));
    end

    // Four-phase order on the ADC bus
    always @(negedge clk) begin
        if (!rst) begin
            if (req_q && !adc_req && !ack_q)
                abort_run("ADC request dropped before the acknowledge arrived");
            if (!req_q && adc_req && ack_q)
                abort_run("ADC request raised while the previous acknowledge was still high");
            if (req_q && adc_req && adc_cmd != cmd_q)
                abort_run("ADC command changed while the request was high");
        end
        req_q <= adc_req;
        ack_q <= adc_ack;
        cmd_q <= adc_cmd;
    end

    initial begin
        void'($urandom(32'hd17eb33e));
        cycle_cnt = 0;
        rst = 1'b1;
        start = 1'b0;
        ram_base = '0;
        rd_addr = '0;
        rd_check = 1'b0;
        rd_exp = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("done", 32'(done), 32'(1'b0));
        compare_value("adc_req", 32'(adc_req), 32'(1'b0));

        run_acquisition(BASE_A);
        compare_value("status.device_type", 32'(status.device_type), 32'(8'h5A));
        compare_value("status.device_temp", 32'(status.device_temp), 32'(16'h1234));
        compare_value("reset_seen", 32'(reset_seen), 32'(1'b1));
        compare_value("conf_value", 32'(conf_value), 32'(CONF_EXP));
        compare_value("conf_in_order", 32'(conf_in_order), 32'(1'b1));
        verify_bytes(BASE_A, 0, 0, `ACQ_NUM_FRAMES * 8 - 1);

        repeat (4) @(posedge clk);
        run_acquisition(BASE_B);   // Wraps past 12'hFFF
        verify_bytes(BASE_B, `ACQ_NUM_FRAMES, 0, `ACQ_NUM_FRAMES * 8 - 1);
        // First run bytes beyond the wrapped second run
        verify_bytes(BASE_A, 0, KEPT_FIRST, `ACQ_NUM_FRAMES * 8 - 1);

        $display("All tests passed");
        $finish;
    end

endmodule
